// ==== include/axis_fifo_defines.svh ====
`ifndef AXIS_FIFO_DEFINES_SVH
`define AXIS_FIFO_DEFINES_SVH

// Stream data word width in bits
`define AXF_DATA_W 32

// Number of FIFO entries, a power of two
`define AXF_DEPTH 16

// Level count must hold AXF_DEPTH itself
`define AXF_LEVEL_W 5

`endif

// ==== rtl/axis_beat_pkg.sv ====
`default_nettype none

`include "axis_fifo_defines.svh"

package axis_beat_pkg;

   // Stored beat is the data word with the last flag on top
   localparam int BEAT_W = `AXF_DATA_W + 1;

   // One stream data word
   typedef logic [`AXF_DATA_W-1:0] data_t;

   // Payload that moves through slices and FIFO
   typedef logic [BEAT_W-1:0] beat_t;

endpackage

`default_nettype wire

// ==== rtl/axis_fifo_cfg_pkg.sv ====
`default_nettype none

`include "axis_fifo_defines.svh"

package axis_fifo_cfg_pkg;

   // Register slice build mode
   typedef enum logic [1:0] {
      SLICE_FULL   = 2'd0,
      SLICE_LIGHT  = 2'd1,
      SLICE_BYPASS = 2'd2
   } slice_mode_e;

   // FIFO fill level, counts up to the depth inclusive
   typedef logic [`AXF_LEVEL_W-1:0] level_t;

endpackage

`default_nettype wire

// ==== rtl/axis_reg_slice.sv ====
`timescale 1ns/1ps
`default_nettype none

module axis_reg_slice
   import axis_fifo_cfg_pkg::*;
#(
   parameter int          DATA_W = 32,
   parameter slice_mode_e MODE   = SLICE_FULL
) (
   input  wire logic              ACLK,
   input  wire logic              ARESET,
   input  wire logic [DATA_W-1:0] s_payload_i,
   input  wire logic              s_valid_i,
   output logic                   s_ready_o,
   output logic      [DATA_W-1:0] m_payload_o,
   output logic                   m_valid_o,
   input  wire logic              m_ready_i
);

   if (MODE == SLICE_FULL) begin : g_full
      // Bit 0 of the state is the output valid
      localparam logic [1:0] ST_EMPTY = 2'b10;
      localparam logic [1:0] ST_ONE   = 2'b11;
      localparam logic [1:0] ST_TWO   = 2'b01;

      logic [1:0]        state_q;
      logic [DATA_W-1:0] main_q;
      logic [DATA_W-1:0] spare_q;
      logic              s_ready_q;
      logic              rst_d1_q;
      logic              s_hs;
      logic              load_main;
      logic              main_from_spare;

      assign s_hs            = s_valid_i & s_ready_q;
      assign main_from_spare = (state_q == ST_TWO);

      always_comb begin
         case (state_q)
            ST_EMPTY: load_main = s_hs;
            ST_ONE:   load_main = s_hs & m_ready_i;
            ST_TWO:   load_main = m_ready_i;
            default:  load_main = 1'b0;
         endcase
      end

      // Main register feeds the output, spare catches a beat under stall
      always_ff @(posedge ACLK) begin
         if (load_main) begin
            if (main_from_spare) begin
               main_q <= spare_q;
            end else begin
               main_q <= s_payload_i;
            end
         end
         if (s_hs) begin
            spare_q <= s_payload_i;
         end
      end

      always_ff @(posedge ACLK) begin
         rst_d1_q <= ARESET;
      end

      always_ff @(posedge ACLK) begin
         if (ARESET) begin
            state_q   <= ST_EMPTY;
            s_ready_q <= 1'b0;
         end else if (rst_d1_q) begin
            // Ready released one cycle after reset
            s_ready_q <= 1'b1;
         end else begin
            case (state_q)
               ST_EMPTY: begin
                  if (s_hs) begin
                     state_q <= ST_ONE;
                  end
               end
               ST_ONE: begin
                  if (m_ready_i && !s_hs) begin
                     state_q <= ST_EMPTY;
                  end else if (!m_ready_i && s_hs) begin
                     state_q   <= ST_TWO;
                     s_ready_q <= 1'b0;
                  end
               end
               ST_TWO: begin
                  if (m_ready_i) begin
                     state_q   <= ST_ONE;
                     s_ready_q <= 1'b1;
                  end
               end
               default: begin
                  state_q <= ST_EMPTY;
               end
            endcase
         end
      end

      assign s_ready_o   = s_ready_q;
      assign m_valid_o   = state_q[0];
      assign m_payload_o = main_q;

      // Nothing leaves and nothing is accepted while reset is held
      a_full_reset_quiet: assert property (@(posedge ACLK)
         ARESET |=> !m_valid_o && !s_ready_o);

   end else if (MODE == SLICE_LIGHT) begin : g_light
      logic [DATA_W-1:0] store_q;
      logic              s_ready_q;
      logic              m_valid_q;
      logic              rst_d1_q;

      always_ff @(posedge ACLK) begin
         rst_d1_q <= ARESET;
      end

      // Alternates between taking one beat and presenting it
      always_ff @(posedge ACLK) begin
         if (ARESET) begin
            s_ready_q <= 1'b0;
            m_valid_q <= 1'b0;
         end else if (rst_d1_q) begin
            s_ready_q <= 1'b1;
         end else if (m_valid_q && m_ready_i) begin
            s_ready_q <= 1'b1;
            m_valid_q <= 1'b0;
         end else if (s_valid_i && s_ready_q) begin
            s_ready_q <= 1'b0;
            m_valid_q <= 1'b1;
         end
      end

      // Tracks the input until a beat is held
      always_ff @(posedge ACLK) begin
         if (!m_valid_q) begin
            store_q <= s_payload_i;
         end
      end

      assign s_ready_o   = s_ready_q;
      assign m_valid_o   = m_valid_q;
      assign m_payload_o = store_q;

   end else begin : g_bypass
      assign m_payload_o = s_payload_i;
      assign m_valid_o   = s_valid_i;
      assign s_ready_o   = m_ready_i;
   end

   // A stalled beat keeps valid and payload until it moves
   a_out_stable: assert property (@(posedge ACLK) disable iff (ARESET)
      m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_payload_o));

endmodule

`default_nettype wire

// ==== rtl/axis_sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axis_fifo_defines.svh"

module axis_sync_fifo
   import axis_beat_pkg::*;
   import axis_fifo_cfg_pkg::*;
#(
   parameter int DEPTH = `AXF_DEPTH
) (
   input  wire logic  ACLK,
   input  wire logic  ARESET,
   input  wire beat_t wr_beat_i,
   input  wire logic  wr_valid_i,
   output logic       wr_ready_o,
   output beat_t      rd_beat_o,
   output logic       rd_valid_o,
   input  wire logic  rd_ready_i,
   output level_t     level_o
);

   localparam int PTR_W = $clog2(DEPTH);

   beat_t            mem_q [DEPTH];
   beat_t            head_q;
   logic [PTR_W:0]   wr_ptr_q;
   logic [PTR_W:0]   rd_ptr_q;
   logic [PTR_W:0]   rd_ptr_nxt;
   level_t           level_q;
   level_t           level_nxt;
   logic             wr_ready_q;
   logic             rst_d1_q;
   logic             wr_hs;
   logic             rd_hs;
   logic             load_head;

   assign wr_hs = wr_valid_i & wr_ready_q;
   assign rd_hs = rd_valid_o & rd_ready_i;

   assign rd_ptr_nxt = rd_ptr_q + {{PTR_W{1'b0}}, rd_hs};

   // Head is refilled after a read or while the FIFO is empty
   assign load_head = rd_hs | ~rd_valid_o;

   always_comb begin
      case ({wr_hs, rd_hs})
         2'b10:   level_nxt = level_q + 1'b1;
         2'b01:   level_nxt = level_q - 1'b1;
         default: level_nxt = level_q;
      endcase
   end

   always_ff @(posedge ACLK) begin
      if (wr_hs) begin
         mem_q[wr_ptr_q[PTR_W-1:0]] <= wr_beat_i;
      end
   end

   // The entry being written this cycle goes straight to the head
   always_ff @(posedge ACLK) begin
      if (load_head) begin
         if (rd_ptr_nxt == wr_ptr_q) begin
            head_q <= wr_beat_i;
         end else begin
            head_q <= mem_q[rd_ptr_nxt[PTR_W-1:0]];
         end
      end
   end

   always_ff @(posedge ACLK) begin
      rst_d1_q <= ARESET;
   end

   always_ff @(posedge ACLK) begin
      if (ARESET) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         level_q    <= '0;
         wr_ready_q <= 1'b0;
      end else begin
         if (wr_hs) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         rd_ptr_q <= rd_ptr_nxt;
         level_q  <= level_nxt;
         if (rst_d1_q) begin
            wr_ready_q <= 1'b1;
         end else begin
            wr_ready_q <= (level_nxt != level_t'(DEPTH));
         end
      end
   end

   assign wr_ready_o = wr_ready_q;
   assign rd_beat_o  = head_q;
   assign rd_valid_o = (level_q != '0);
   assign level_o    = level_q;

   a_level_max: assert property (@(posedge ACLK) disable iff (ARESET)
      level_q <= level_t'(DEPTH));

   // Registered ready must already be low once the last slot fills
   a_full_no_ready: assert property (@(posedge ACLK) disable iff (ARESET)
      level_q == level_t'(DEPTH) |-> !wr_ready_o);

endmodule

`default_nettype wire

// ==== rtl/axis_fifo_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axis_fifo_defines.svh"

module axis_fifo_top
   import axis_beat_pkg::*;
   import axis_fifo_cfg_pkg::*;
(
   input  wire logic  ACLK,
   input  wire logic  ARESET,
   input  wire data_t s_data_i,
   input  wire logic  s_last_i,
   input  wire logic  s_valid_i,
   output logic       s_ready_o,
   output data_t      m_data_o,
   output logic       m_last_o,
   output logic       m_valid_o,
   input  wire logic  m_ready_i,
   output level_t     level_o
);

   beat_t in_beat;
   beat_t wr_beat;
   logic  wr_valid;
   logic  wr_ready;
   beat_t rd_beat;
   logic  rd_valid;
   logic  rd_ready;
   beat_t out_beat;

   // Last flag rides above the data word
   assign in_beat = {s_last_i, s_data_i};

   axis_reg_slice #(
      .DATA_W (BEAT_W),
      .MODE   (SLICE_FULL)
   ) u_in_slice (
      .ACLK        (ACLK),
      .ARESET      (ARESET),
      .s_payload_i (in_beat),
      .s_valid_i   (s_valid_i),
      .s_ready_o   (s_ready_o),
      .m_payload_o (wr_beat),
      .m_valid_o   (wr_valid),
      .m_ready_i   (wr_ready)
   );

   axis_sync_fifo #(
      .DEPTH (`AXF_DEPTH)
   ) u_fifo (
      .ACLK       (ACLK),
      .ARESET     (ARESET),
      .wr_beat_i  (wr_beat),
      .wr_valid_i (wr_valid),
      .wr_ready_o (wr_ready),
      .rd_beat_o  (rd_beat),
      .rd_valid_o (rd_valid),
      .rd_ready_i (rd_ready),
      .level_o    (level_o)
   );

   // Light slice at the output, half rate at best
   axis_reg_slice #(
      .DATA_W (BEAT_W),
      .MODE   (SLICE_LIGHT)
   ) u_out_slice (
      .ACLK        (ACLK),
      .ARESET      (ARESET),
      .s_payload_i (rd_beat),
      .s_valid_i   (rd_valid),
      .s_ready_o   (rd_ready),
      .m_payload_o (out_beat),
      .m_valid_o   (m_valid_o),
      .m_ready_i   (m_ready_i)
   );

   assign {m_last_o, m_data_o} = out_beat;

endmodule

`default_nettype wire

// ==== sim/axis_fifo_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axis_fifo_defines.svh"

module axis_fifo_checker
   import axis_beat_pkg::*;
   import axis_fifo_cfg_pkg::*;
(
   input  wire logic   ACLK,
   input  wire logic   ARESET,
   input  wire logic   in_valid_i,
   input  wire logic   in_ready_i,
   input  wire data_t  out_data_i,
   input  wire logic   out_last_i,
   input  wire logic   out_valid_i,
   input  wire logic   out_ready_i,
   input  wire level_t level_i,
   output int          err_count_o,
   output int          rx_count_o,
   output int          exp_count_o
);

   data_t exp_data_q[$];
   logic  exp_last_q[$];
   data_t data_prev;
   logic  last_prev;
   logic  rst_prev  = 1'b0;
   logic  hold_prev = 1'b0;
   int    errs      = 0;
   int    rx        = 0;
   int    in_cnt    = 0;
   int    exp_total = 0;

   initial begin : load_expected
      int         fd;
      string      line;
      data_t      d;
      logic [3:0] last_v;
      int         idle;
      fd = $fopen("sim/axis_fifo_testdata.txt", "r");
      if (fd == 0) begin
         $display("Checker could not open the data file");
         errs++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) != 0) begin
               // Comment and blank lines do not scan
               if ($sscanf(line, "%h %h %d", d, last_v, idle) == 3) begin
                  exp_data_q.push_back(d);
                  exp_last_q.push_back(last_v[0]);
               end
            end
         end
         $fclose(fd);
         exp_total = exp_data_q.size();
      end
   end

   always @(posedge ACLK) begin
      if (rst_prev) begin
         // Quiet outputs during reset and in the first cycle after it
         if (in_ready_i !== 1'b0)
            $display("ERR %0t s_ready_o expected 0 actual %b", $time, in_ready_i);
         if (out_valid_i !== 1'b0)
            $display("ERR %0t m_valid_o expected 0 actual %b", $time, out_valid_i);
         if (level_i !== '0)
            $display("ERR %0t level_o expected 0 actual %0d", $time, level_i);
         if (in_ready_i !== 1'b0 || out_valid_i !== 1'b0 || level_i !== '0)
            errs++;
      end else if (!ARESET) begin
         if (hold_prev) begin
            if (out_valid_i !== 1'b1) begin
               $display("ERR %0t m_valid_o expected 1 actual %b", $time, out_valid_i);
               errs++;
            end
            if (out_data_i !== data_prev) begin
               $display("ERR %0t m_data_o expected %h actual %h", $time,
                        data_prev, out_data_i);
               errs++;
            end
            if (out_last_i !== last_prev) begin
               $display("ERR %0t m_last_o expected %b actual %b", $time,
                        last_prev, out_last_i);
               errs++;
            end
         end
         if (out_valid_i && out_ready_i) begin
            if (exp_data_q.size() == 0) begin
               $display("Unexpected output beat at %0t with data %h", $time, out_data_i);
               errs++;
            end else begin
               if (out_data_i !== exp_data_q[0]) begin
                  $display("ERR %0t m_data_o expected %h actual %h", $time,
                           exp_data_q[0], out_data_i);
                  errs++;
               end
               if (out_last_i !== exp_last_q[0]) begin
                  $display("ERR %0t m_last_o expected %b actual %b", $time,
                           exp_last_q[0], out_last_i);
                  errs++;
               end
               void'(exp_data_q.pop_front());
               void'(exp_last_q.pop_front());
            end
            rx++;
         end
         if (in_valid_i && in_ready_i)
            in_cnt++;
         if (level_i > `AXF_DEPTH) begin
            $display("ERR %0t level_o expected <= %0d actual %0d", $time, `AXF_DEPTH, level_i);
            errs++;
         end
         // FIFO, two input-slice registers and one output-slice register
         if (in_cnt - rx > `AXF_DEPTH + 3) begin
            $display("ERR %0t beats_in_flight expected <= %0d actual %0d", $time,
                     `AXF_DEPTH + 3, in_cnt - rx);
            errs++;
         end
      end
      rst_prev  <= ARESET;
      hold_prev <= !ARESET && out_valid_i && !out_ready_i;
      data_prev <= out_data_i;
      last_prev <= out_last_i;
   end

   assign err_count_o = errs;
   assign rx_count_o  = rx;
   assign exp_count_o = exp_total;

endmodule

`default_nettype wire

// ==== sim/tb_axis_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axis_fifo_defines.svh"

module tb_axis_fifo
   import axis_beat_pkg::*;
   import axis_fifo_cfg_pkg::*;
();

   localparam int READY_TIMEOUT = 200;
   localparam int HOLD_TIMEOUT  = 1000;
   localparam int DRAIN_TIMEOUT = 4000;

   logic   ACLK;
   logic   ARESET;
   data_t  s_data_i;
   logic   s_last_i;
   logic   s_valid_i;
   logic   s_ready_o;
   data_t  m_data_o;
   logic   m_last_o;
   logic   m_valid_o;
   logic   m_ready_i;
   level_t level_o;

   data_t  beat_data[$];
   logic   beat_last[$];
   int     beat_idle[$];
   int     bp_mode;
   int     tb_errs;
   int     chk_errs;
   int     rx_count;
   int     exp_count;

   axis_fifo_top uut (
      .ACLK      (ACLK),
      .ARESET    (ARESET),
      .s_data_i  (s_data_i),
      .s_last_i  (s_last_i),
      .s_valid_i (s_valid_i),
      .s_ready_o (s_ready_o),
      .m_data_o  (m_data_o),
      .m_last_o  (m_last_o),
      .m_valid_o (m_valid_o),
      .m_ready_i (m_ready_i),
      .level_o   (level_o)
   );

   axis_fifo_checker u_checker (
      .ACLK        (ACLK),
      .ARESET      (ARESET),
      .in_valid_i  (s_valid_i),
      .in_ready_i  (s_ready_o),
      .out_data_i  (m_data_o),
      .out_last_i  (m_last_o),
      .out_valid_i (m_valid_o),
      .out_ready_i (m_ready_i),
      .level_i     (level_o),
      .err_count_o (chk_errs),
      .rx_count_o  (rx_count),
      .exp_count_o (exp_count)
   );

   initial begin
      ACLK = 1'b0;
      forever #50 ACLK = ~ACLK;
   end

   // Output ready: held low, then 20 percent, then always high
   always @(negedge ACLK) begin
      case (bp_mode)
         0:       m_ready_i = 1'b0;
         1:       m_ready_i = (($urandom % 100) < 20);
         default: m_ready_i = 1'b1;
      endcase
   end

   task automatic load_stimulus();
      int         fd;
      string      line;
      data_t      d;
      logic [3:0] last_v;
      int         idle;
      fd = $fopen("sim/axis_fifo_testdata.txt", "r");
      if (fd == 0) begin
         $display("Testbench could not open the data file");
         tb_errs++;
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         if ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "%h %h %d", d, last_v, idle) == 3) begin
               beat_data.push_back(d);
               beat_last.push_back(last_v[0]);
               beat_idle.push_back(idle);
            end
         end
      end
      $fclose(fd);
      if (beat_data.size() == 0) begin
         $display("The data file holds no beats");
         tb_errs++;
      end
   endtask

   // Called at a falling edge, returns at a falling edge
   task automatic send_beat(input data_t d, input logic l);
      int t;
      s_data_i  = d;
      s_last_i  = l;
      s_valid_i = 1'b1;
      t = 0;
      while (!s_ready_o && t < READY_TIMEOUT) begin
         @(negedge ACLK);
         t++;
      end
      if (t >= READY_TIMEOUT) begin
         $display("Timeout at %0t waiting for s_ready_o", $time);
         tb_errs++;
      end else begin
         @(posedge ACLK);
         @(negedge ACLK);
      end
      s_valid_i = 1'b0;
   endtask

   task automatic drive_all();
      for (int i = 0; i < beat_data.size(); i++) begin
         repeat (beat_idle[i]) @(negedge ACLK);
         send_beat(beat_data[i], beat_last[i]);
      end
   endtask

   task automatic pace_backpressure();
      int t;
      t = 0;
      while (s_ready_o && t < HOLD_TIMEOUT) begin
         @(negedge ACLK);
         t++;
      end
      if (t >= HOLD_TIMEOUT) begin
         $display("Timeout: s_ready_o never dropped while m_ready_i was held low");
         tb_errs++;
      end
      bp_mode <= 1;
      t = 0;
      while (rx_count < exp_count / 2 && t < DRAIN_TIMEOUT) begin
         @(negedge ACLK);
         t++;
      end
      if (t >= DRAIN_TIMEOUT) begin
         $display("Timeout: output stalled during the heavy back-pressure phase");
         tb_errs++;
      end
      bp_mode <= 2;
   endtask

   task automatic wait_drain();
      int t;
      t = 0;
      while (!(rx_count == exp_count && level_o == '0 && !m_valid_o) && t < DRAIN_TIMEOUT) begin
         @(negedge ACLK);
         t++;
      end
      if (t >= DRAIN_TIMEOUT) begin
         $display("Timeout: output did not drain, %0d of %0d beats seen", rx_count, exp_count);
         tb_errs++;
      end
      repeat (5) @(negedge ACLK);
      if (m_valid_o !== 1'b0) begin
         $display("ERR %0t m_valid_o expected 0 actual %b", $time, m_valid_o);
         tb_errs++;
      end
      if (level_o !== '0) begin
         $display("ERR %0t level_o expected 0 actual %0d", $time, level_o);
         tb_errs++;
      end
   endtask

   initial begin
      int t;
      s_data_i  = '0;
      s_last_i  = 1'b0;
      s_valid_i = 1'b0;
      m_ready_i = 1'b0;
      ARESET    = 1'b1;
      bp_mode   = 0;
      tb_errs   = 0;
      void'($urandom(32'h211c_2312));
      load_stimulus();
      repeat (10) @(negedge ACLK);
      ARESET = 1'b0;
      t = 0;
      while (!s_ready_o && t < 20) begin
         @(negedge ACLK);
         t++;
      end
      if (t >= 20) begin
         $display("Timeout: s_ready_o never rose after reset");
         tb_errs++;
      end
      fork
         drive_all();
         pace_backpressure();
      join
      wait_drain();
      $display("Errors: checker %0d, testbench %0d; beats received %0d of %0d",
               chk_errs, tb_errs, rx_count, exp_count);
      if (chk_errs == 0 && tb_errs == 0 && rx_count == exp_count) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim/axis_fifo_testdata.txt ====
# data_hex last idle_cycles
# idle_cycles is the number of idle cycles before the beat is offered
00000001 0 0
00000002 0 0
00000003 0 1
00000004 1 0
a5a5a5a5 0 2
5a5a5a5a 0 0
deadbeef 1 0
00000010 0 0
00000011 0 3
00000012 0 0
00000013 1 1
ffffffff 0 0
00000000 1 0
12345678 0 0
9abcdef0 0 2
0f0f0f0f 0 0
f0f0f0f0 1 0
00000020 0 1
00000021 0 0
00000022 0 0
00000023 1 0
cafef00d 0 3
0badc0de 0 0
80000000 0 0
7fffffff 0 1
00000030 1 0

// ==== vlog.f ====
+incdir+include
rtl/axis_beat_pkg.sv
rtl/axis_fifo_cfg_pkg.sv
rtl/axis_reg_slice.sv
rtl/axis_sync_fifo.sv
rtl/axis_fifo_top.sv
sim/axis_fifo_checker.sv
sim/tb_axis_fifo.sv

// ==== Bender.yml ====
package:
  name: axis_fifo

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/axis_beat_pkg.sv
      - rtl/axis_fifo_cfg_pkg.sv
      - rtl/axis_reg_slice.sv
      - rtl/axis_sync_fifo.sv
      - rtl/axis_fifo_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/axis_fifo_checker.sv
      - sim/tb_axis_fifo.sv
